// ==== hw/io_defines.svh ====
`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

// bus word width
`define IO_DATA_BITS 32

// memory-mapped register addresses, one 32-bit word each
`define IO_ADDR_HEX   32'hFFFF_F000
`define IO_ADDR_LEDR  32'hFFFF_F020
`define IO_ADDR_KDATA 32'hFFFF_F080
`define IO_ADDR_KCTL  32'hFFFF_F084
`define IO_ADDR_SDATA 32'hFFFF_F090
`define IO_ADDR_SCTL  32'hFFFF_F094
`define IO_ADDR_TCNT  32'hFFFF_F100
`define IO_ADDR_TLIM  32'hFFFF_F104
`define IO_ADDR_TCTL  32'hFFFF_F108

// register widths
`define IO_HEX_BITS  24
`define IO_LEDR_BITS 10
`define IO_KEY_BITS  4
`define IO_SW_BITS   10
`define IO_CTL_BITS  2

`define IO_HEX_RESET 24'hFEDEAD

// 113 MHz core clock
`define IO_CYCLES_PER_MS   113000
`define IO_DEBOUNCE_CYCLES (10 * `IO_CYCLES_PER_MS)

`define IO_CTL_READY   0
`define IO_CTL_OVERRUN 1

`endif

// ==== hw/ioPkg.sv ====
`include "io_defines.svh"

package ioPkg;

	// one word on the peripheral bus
	typedef logic [`IO_DATA_BITS-1:0] ioWord_t;

	// register addressed by a bus access
	typedef enum logic [3:0] {
		REG_NONE,
		// display side
		REG_HEX,
		REG_LEDR,
		// key pair
		REG_KDATA,
		REG_KCTL,
		// switch pair
		REG_SDATA,
		REG_SCTL,
		// timer
		REG_TCNT,
		REG_TLIM,
		REG_TCTL
	} ioReg_t;

endpackage

// ==== hw/displayPorts.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module displayPorts
	import ioPkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  ioWord_t                  wrData,
	input  logic                     hexWrite,
	input  logic                     ledrWrite,
	output logic [`IO_HEX_BITS-1:0]  hexValue,
	output logic [`IO_LEDR_BITS-1:0] ledrValue,
	output logic [6:0]               hex0,
	output logic [6:0]               hex1,
	output logic [6:0]               hex2,
	output logic [6:0]               hex3,
	output logic [6:0]               hex4,
	output logic [6:0]               hex5,
	output logic [`IO_LEDR_BITS-1:0] ledr
);

	// active-low segments, bit order gfedcba
	function automatic logic [6:0] segments(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'hA: return 7'b0001000;
			4'hB: return 7'b0000011;
			4'hC: return 7'b1000110;
			4'hD: return 7'b0100001;
			4'hE: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hexValue  <= `IO_HEX_RESET;
			ledrValue <= '0;
		end else begin
			if (hexWrite) begin
				hexValue <= wrData[`IO_HEX_BITS-1:0];
			end
			if (ledrWrite) begin
				ledrValue <= wrData[`IO_LEDR_BITS-1:0];
			end
		end
	end

	// hex0 shows the least significant nibble
	assign hex0 = segments(hexValue[3:0]);
	assign hex1 = segments(hexValue[7:4]);
	assign hex2 = segments(hexValue[11:8]);
	assign hex3 = segments(hexValue[15:12]);
	assign hex4 = segments(hexValue[19:16]);
	assign hex5 = segments(hexValue[23:20]);
	assign ledr = ledrValue;

endmodule

// ==== hw/timerUnit.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module timerUnit
	import ioPkg::*;
#(
	parameter int cyclesPerMs = `IO_CYCLES_PER_MS
) (
	input  logic                    clk,
	input  logic                    reset,
	input  ioWord_t                 wrData,
	input  logic                    tcntWrite,
	input  logic                    tlimWrite,
	input  logic                    tctlWrite,
	output ioWord_t                 tcnt,
	output ioWord_t                 tlim,
	output logic [`IO_CTL_BITS-1:0] tctl
);

	localparam int PRE_BITS = (cyclesPerMs > 1) ? $clog2(cyclesPerMs) : 1;

	logic [PRE_BITS-1:0] preCount;
	logic                msTick;
	logic                limitHit;

	// free-running millisecond prescaler
	assign msTick = (preCount == PRE_BITS'(cyclesPerMs - 1));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			preCount <= '0;
		end else if (msTick) begin
			preCount <= '0;
		end else begin
			preCount <= preCount + 1'b1;
		end
	end

	// wrap only on a tick, and only with a nonzero limit
	assign limitHit = msTick && (tlim != '0) && (tcnt == tlim - 1'b1);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tcnt <= '0;
			tlim <= '0;
		end else begin
			if (tcntWrite) begin
				tcnt <= wrData;
			end else if (limitHit) begin
				tcnt <= '0;
			end else if (msTick) begin
				tcnt <= tcnt + 1'b1;
			end
			if (tlimWrite) begin
				tlim <= wrData;
			end
		end
	end

	// control writes can only clear status bits
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tctl <= '0;
		end else if (tctlWrite) begin
			tctl <= tctl & wrData[`IO_CTL_BITS-1:0];
		end else if (limitHit) begin
			tctl[`IO_CTL_READY]   <= 1'b1;
			tctl[`IO_CTL_OVERRUN] <= tctl[`IO_CTL_OVERRUN] | tctl[`IO_CTL_READY];
		end
	end

endmodule

// ==== hw/inputPorts.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module inputPorts
	import ioPkg::*;
#(
	parameter int debounceCycles = `IO_DEBOUNCE_CYCLES
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [`IO_KEY_BITS-1:0] key,
	input  logic [`IO_SW_BITS-1:0]  sw,
	input  ioWord_t                 wrData,
	input  logic                    kctlWrite,
	input  logic                    sctlWrite,
	input  logic                    kdataRead,
	input  logic                    sdataRead,
	output logic [`IO_KEY_BITS-1:0] kdata,
	output logic [`IO_CTL_BITS-1:0] kctl,
	output logic [`IO_SW_BITS-1:0]  sdata,
	output logic [`IO_CTL_BITS-1:0] sctl
);

	localparam int DB_BITS = $clog2(debounceCycles + 1);

	logic [`IO_KEY_BITS-1:0] keyPressed;
	logic                    keyCapture;
	logic [DB_BITS-1:0]      swCount;
	logic                    swDiffer;
	logic                    swCapture;

	// status update shared by the key and switch pairs
	function automatic logic [`IO_CTL_BITS-1:0] nextCtl(
		input logic [`IO_CTL_BITS-1:0] ctl,
		input logic                    capture,
		input logic                    ctlWrite,
		input logic                    dataRead,
		input logic [`IO_CTL_BITS-1:0] mask
	);
		logic [`IO_CTL_BITS-1:0] result;
		result = ctl;
		if (ctlWrite) begin
			result = ctl & mask;
		end
		if (dataRead) begin
			result[`IO_CTL_READY] = 1'b0;
		end
		// a new capture wins over a clearing read in the same cycle
		if (capture) begin
			result[`IO_CTL_READY]   = 1'b1;
			result[`IO_CTL_OVERRUN] = ctl[`IO_CTL_OVERRUN] | ctl[`IO_CTL_READY];
		end
		return result;
	endfunction

	// keys are active low on the board
	assign keyPressed = ~key;
	assign keyCapture = (keyPressed != kdata);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			kdata <= '0;
			kctl  <= '0;
		end else begin
			if (keyCapture) begin
				kdata <= keyPressed;
			end
			kctl <= nextCtl(kctl, keyCapture, kctlWrite, kdataRead,
				wrData[`IO_CTL_BITS-1:0]);
		end
	end

	// switch value must stay stable for debounceCycles before capture
	assign swDiffer  = (sw != sdata);
	assign swCapture = swDiffer && (swCount == DB_BITS'(debounceCycles));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			swCount <= '0;
		end else if (!swDiffer || swCapture) begin
			swCount <= '0;
		end else begin
			swCount <= swCount + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sdata <= '0;
			sctl  <= '0;
		end else begin
			if (swCapture) begin
				sdata <= sw;
			end
			sctl <= nextCtl(sctl, swCapture, sctlWrite, sdataRead,
				wrData[`IO_CTL_BITS-1:0]);
		end
	end

endmodule

// ==== hw/ioBusDecoder.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module ioBusDecoder
	import ioPkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  ioWord_t                  busAddr,
	input  ioWord_t                  busWrData,
	input  logic                     busWrite,
	input  logic                     busRead,
	output ioWord_t                  busRdData,
	output logic                     busRdValid,
	output logic                     hexWrite,
	output logic                     ledrWrite,
	output logic                     tcntWrite,
	output logic                     tlimWrite,
	output logic                     tctlWrite,
	output logic                     kctlWrite,
	output logic                     sctlWrite,
	output logic                     kdataRead,
	output logic                     sdataRead,
	output ioWord_t                  wrData,
	input  logic [`IO_HEX_BITS-1:0]  hexValue,
	input  logic [`IO_LEDR_BITS-1:0] ledrValue,
	input  ioWord_t                  tcnt,
	input  ioWord_t                  tlim,
	input  logic [`IO_CTL_BITS-1:0]  tctl,
	input  logic [`IO_KEY_BITS-1:0]  kdata,
	input  logic [`IO_CTL_BITS-1:0]  kctl,
	input  logic [`IO_SW_BITS-1:0]   sdata,
	input  logic [`IO_CTL_BITS-1:0]  sctl
);

	ioReg_t  selReg;
	ioWord_t rdMux;

	// address compare, the only one in the subsystem
	always_comb begin
		case (busAddr)
			`IO_ADDR_HEX:   selReg = REG_HEX;
			`IO_ADDR_LEDR:  selReg = REG_LEDR;
			`IO_ADDR_KDATA: selReg = REG_KDATA;
			`IO_ADDR_KCTL:  selReg = REG_KCTL;
			`IO_ADDR_SDATA: selReg = REG_SDATA;
			`IO_ADDR_SCTL:  selReg = REG_SCTL;
			`IO_ADDR_TCNT:  selReg = REG_TCNT;
			`IO_ADDR_TLIM:  selReg = REG_TLIM;
			`IO_ADDR_TCTL:  selReg = REG_TCTL;
			default:        selReg = REG_NONE;
		endcase
	end

	// write strobes, data registers of the input pair are read-only
	assign hexWrite  = busWrite && (selReg == REG_HEX);
	assign ledrWrite = busWrite && (selReg == REG_LEDR);
	assign tcntWrite = busWrite && (selReg == REG_TCNT);
	assign tlimWrite = busWrite && (selReg == REG_TLIM);
	assign tctlWrite = busWrite && (selReg == REG_TCTL);
	assign kctlWrite = busWrite && (selReg == REG_KCTL);
	assign sctlWrite = busWrite && (selReg == REG_SCTL);

	// data reads clear the ready bit in the input ports
	assign kdataRead = busRead && (selReg == REG_KDATA);
	assign sdataRead = busRead && (selReg == REG_SDATA);

	assign wrData = busWrData;

	// zero-extended read select, unmapped reads give zero
	always_comb begin
		case (selReg)
			REG_HEX:   rdMux = ioWord_t'(hexValue);
			REG_LEDR:  rdMux = ioWord_t'(ledrValue);
			REG_KDATA: rdMux = ioWord_t'(kdata);
			REG_KCTL:  rdMux = ioWord_t'(kctl);
			REG_SDATA: rdMux = ioWord_t'(sdata);
			REG_SCTL:  rdMux = ioWord_t'(sctl);
			REG_TCNT:  rdMux = tcnt;
			REG_TLIM:  rdMux = tlim;
			REG_TCTL:  rdMux = ioWord_t'(tctl);
			default:   rdMux = '0;
		endcase
	end

	// one cycle read latency
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busRdValid <= 1'b0;
		end else begin
			busRdValid <= busRead;
		end
	end

	always_ff @(posedge clk) begin
		if (busRead) begin
			busRdData <= rdMux;
		end
	end

endmodule

// ==== hw/ioSubsystem.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module ioSubsystem
	import ioPkg::*;
#(
	parameter int cyclesPerMs    = `IO_CYCLES_PER_MS,
	parameter int debounceCycles = `IO_DEBOUNCE_CYCLES
) (
	input  logic                     clk,
	input  logic                     reset,
	input  ioWord_t                  busAddr,
	input  ioWord_t                  busWrData,
	input  logic                     busWrite,
	input  logic                     busRead,
	output ioWord_t                  busRdData,
	output logic                     busRdValid,
	input  logic [`IO_KEY_BITS-1:0]  key,
	input  logic [`IO_SW_BITS-1:0]   sw,
	output logic [6:0]               hex0,
	output logic [6:0]               hex1,
	output logic [6:0]               hex2,
	output logic [6:0]               hex3,
	output logic [6:0]               hex4,
	output logic [6:0]               hex5,
	output logic [`IO_LEDR_BITS-1:0] ledr
);

	ioWord_t                  wrData;
	logic                     hexWrite;
	logic                     ledrWrite;
	logic                     tcntWrite;
	logic                     tlimWrite;
	logic                     tctlWrite;
	logic                     kctlWrite;
	logic                     sctlWrite;
	logic                     kdataRead;
	logic                     sdataRead;
	logic [`IO_HEX_BITS-1:0]  hexValue;
	logic [`IO_LEDR_BITS-1:0] ledrValue;
	ioWord_t                  tcnt;
	ioWord_t                  tlim;
	logic [`IO_CTL_BITS-1:0]  tctl;
	logic [`IO_KEY_BITS-1:0]  kdata;
	logic [`IO_CTL_BITS-1:0]  kctl;
	logic [`IO_SW_BITS-1:0]   sdata;
	logic [`IO_CTL_BITS-1:0]  sctl;

	ioBusDecoder u_decoder (.*);

	timerUnit #(.cyclesPerMs(cyclesPerMs)) u_timer (.*);

	inputPorts #(.debounceCycles(debounceCycles)) u_inputs (.*);

	displayPorts u_display (.*);

endmodule

// ==== tests/ioSubsystem_asserts.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module ioSubsystemAsserts (
	input logic                     clk,
	input logic                     reset,
	input logic                     busWrite,
	input logic                     busRead,
	input logic                     busRdValid,
	input logic [`IO_LEDR_BITS-1:0] ledr,
	input logic [`IO_CTL_BITS-1:0]  kctl,
	input logic [`IO_CTL_BITS-1:0]  sctl,
	input logic [`IO_CTL_BITS-1:0]  tctl
);

	int failCount = 0;

	// read data is valid exactly one cycle after each read strobe
	rdValidTiming: assert property (@(posedge clk) disable iff (reset)
		busRdValid == $past(busRead))
	else begin
		$error("busRdValid did not follow busRead by exactly one cycle");
		failCount++;
	end

	noStrobeOverlap: assert property (@(posedge clk) !(busWrite && busRead))
	else begin
		$error("busWrite and busRead high in the same cycle");
		failCount++;
	end

	resetState: assert property (@(posedge clk) reset |->
		(!busRdValid && ledr == '0 && !kctl[`IO_CTL_READY] &&
		!sctl[`IO_CTL_READY] && !tctl[`IO_CTL_READY]))
	else begin
		$error("outputs or ready bits not cleared during reset");
		failCount++;
	end

endmodule

bind ioSubsystem ioSubsystemAsserts u_asserts (.*);

// ==== tests/ioSubsystemTb.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module ioSubsystemTb
	import ioPkg::*;
();

	localparam int CLK_HALF       = 10;
	localparam int DRIVE_DELAY    = 2;
	localparam int TIMEOUT_CYCLES = 3000;

	// active-low segments gfedcba for hex digits 0 to F
	localparam logic [6:0] SEG_TABLE [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
	};

	logic                     clk;
	logic                     reset;
	ioWord_t                  busAddr;
	ioWord_t                  busWrData;
	logic                     busWrite;
	logic                     busRead;
	ioWord_t                  busRdData;
	logic                     busRdValid;
	logic [`IO_KEY_BITS-1:0]  key;
	logic [`IO_SW_BITS-1:0]   sw;
	logic [6:0]               hex0;
	logic [6:0]               hex1;
	logic [6:0]               hex2;
	logic [6:0]               hex3;
	logic [6:0]               hex4;
	logic [6:0]               hex5;
	logic [`IO_LEDR_BITS-1:0] ledr;

	int          errorCount = 0;
	int          cycleCount = 0;
	logic [31:0] lfsrState  = 32'h95d0_5532;

	ioSubsystem #(.cyclesPerMs(10), .debounceCycles(8)) i_dut (.*);

	always #(CLK_HALF) clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// taps 32 22 2 1 with one shift per bit taken
	function automatic ioWord_t randomBits(input int bitCount);
		ioWord_t result;
		result = '0;
		for (int i = 0; i < bitCount; i++) begin
			lfsrState = {lfsrState[30:0],
				lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
			result = {result[30:0], lfsrState[0]};
		end
		return result;
	endfunction

	task automatic checkValue(input string testName, input ioWord_t expected,
		input ioWord_t actual);
		assert (actual === expected) else begin
			errorCount++;
			$display("Fail %s: expected %h, actual %h", testName, expected, actual);
		end
	endtask

	task automatic checkBelow(input string testName, input ioWord_t limit,
		input ioWord_t actual);
		assert (actual < limit) else begin
			errorCount++;
			$display("Fail %s: expected below %0d, actual %0d", testName, limit, actual);
		end
	endtask

	task automatic waitCycles(input int count);
		repeat (count) @(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic busWriteWord(input ioWord_t addr, input ioWord_t data);
		busAddr   = addr;
		busWrData = data;
		busWrite  = 1'b1;
		waitCycles(1);
		busWrite  = 1'b0;
	endtask

	task automatic busReadWord(input ioWord_t addr, output ioWord_t data);
		int waited;
		waited  = 0;
		busAddr = addr;
		busRead = 1'b1;
		waitCycles(1);
		busRead = 1'b0;
		while (!busRdValid && waited < 8) begin
			waitCycles(1);
			waited++;
		end
		data = busRdData;
		assert (busRdValid) else begin
			errorCount++;
			$display("read of address %h got no valid response", addr);
		end
	endtask

	task automatic readAndCheck(input string testName, input ioWord_t addr,
		input ioWord_t expected);
		ioWord_t got;
		busReadWord(addr, got);
		checkValue(testName, expected, got);
	endtask

	task automatic checkDigits(input string testName, input logic [23:0] value);
		logic [6:0] shown [6];
		shown = '{hex0, hex1, hex2, hex3, hex4, hex5};
		for (int i = 0; i < 6; i++) begin
			checkValue($sformatf("%s hex%0d", testName, i),
				ioWord_t'(SEG_TABLE[value[4*i +: 4]]), ioWord_t'(shown[i]));
		end
	endtask

	initial begin
		ioWord_t                 hexVal;
		ioWord_t                 ledrVal;
		ioWord_t                 swVal;
		ioWord_t                 got;
		logic [`IO_KEY_BITS-1:0] pressed;
		int                      assertFails;

		clk       = 1'b0;
		reset     = 1'b0;
		busAddr   = '0;
		busWrData = '0;
		busWrite  = 1'b0;
		busRead   = 1'b0;
		key       = '1;
		sw        = '0;
		#1 reset = 1'b1;
		repeat (5) @(posedge clk);
		#(DRIVE_DELAY) reset = 1'b0;
		waitCycles(1);

		checkDigits("reset", `IO_HEX_RESET);
		checkValue("reset ledr", '0, ioWord_t'(ledr));
		readAndCheck("reset TCTL", `IO_ADDR_TCTL, '0);
		readAndCheck("reset KCTL", `IO_ADDR_KCTL, '0);
		readAndCheck("reset SCTL", `IO_ADDR_SCTL, '0);

		repeat (4) begin
			hexVal  = randomBits(24);
			ledrVal = randomBits(10);
			busWriteWord(`IO_ADDR_HEX, hexVal);
			busWriteWord(`IO_ADDR_LEDR, ledrVal);
			checkDigits("display", hexVal[23:0]);
			checkValue("display ledr", ledrVal, ioWord_t'(ledr));
			readAndCheck("display HEX readback", `IO_ADDR_HEX, hexVal);
			readAndCheck("display LEDR readback", `IO_ADDR_LEDR, ledrVal);
		end
		readAndCheck("display unmapped", 32'hFFFF_F004, '0);
		// key data is read-only
		busWriteWord(`IO_ADDR_KDATA, randomBits(4));
		readAndCheck("display KDATA write ignored", `IO_ADDR_KDATA, '0);

		key = 4'b1110;
		pressed = ~key;
		waitCycles(2);
		readAndCheck("keys KCTL ready", `IO_ADDR_KCTL, 32'd1);
		readAndCheck("keys KDATA", `IO_ADDR_KDATA, ioWord_t'(pressed));
		readAndCheck("keys KCTL cleared by read", `IO_ADDR_KCTL, '0);
		key = 4'b1100;
		waitCycles(2);
		key = 4'b1011;
		waitCycles(2);
		readAndCheck("keys KCTL overrun", `IO_ADDR_KCTL, 32'd3);
		busWriteWord(`IO_ADDR_KCTL, '0);
		readAndCheck("keys KCTL cleared by write", `IO_ADDR_KCTL, '0);

		// glitch shorter than the debounce time
		sw = 10'h155;
		waitCycles(5);
		sw = '0;
		waitCycles(3);
		readAndCheck("switches SDATA after glitch", `IO_ADDR_SDATA, '0);
		readAndCheck("switches SCTL after glitch", `IO_ADDR_SCTL, '0);
		swVal = randomBits(10);
		if (swVal == '0) begin
			swVal = 32'h2AA;
		end
		sw = swVal[9:0];
		waitCycles(12);
		readAndCheck("switches SCTL ready", `IO_ADDR_SCTL, 32'd1);
		readAndCheck("switches SDATA", `IO_ADDR_SDATA, swVal);
		readAndCheck("switches SCTL cleared by read", `IO_ADDR_SCTL, '0);

		busWriteWord(`IO_ADDR_TLIM, 32'd3);
		busWriteWord(`IO_ADDR_TCNT, '0);
		waitCycles(40);
		readAndCheck("timer TCTL ready", `IO_ADDR_TCTL, 32'd1);
		busReadWord(`IO_ADDR_TCNT, got);
		checkBelow("timer TCNT", 32'd3, got);
		waitCycles(30);
		readAndCheck("timer TCTL overrun", `IO_ADDR_TCTL, 32'd3);
		busWriteWord(`IO_ADDR_TCTL, '0);
		readAndCheck("timer TCTL cleared", `IO_ADDR_TCTL, '0);

		waitCycles(2);
		assertFails = i_dut.u_asserts.failCount;
		$display("errors: %0d check failures, %0d assertion failures",
			errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/ioPkg.sv
hw/displayPorts.sv
hw/timerUnit.sv
hw/inputPorts.sv
hw/ioBusDecoder.sv
hw/ioSubsystem.sv
tests/ioSubsystem_asserts.sv
tests/ioSubsystemTb.sv
